// ==== design/logArithPkg.sv ====
// Log values carry 6 integer and 6 fraction bits, so operands wider than 64 bits are not supported
`default_nettype none

package logArithPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point formats
  ////////////////////////////////////////////////////////////////////////////

  // Fraction bits of a log value
  localparam int fracBits = 6;

  // Integer bits of a log value
  localparam int intBits = 6;

  // Log value width without the zero flag
  localparam int logBits = intBits + fracBits;

  // Octave mantissa below the hidden one
  localparam int mantBits = 23;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Base-2 log of an unsigned integer
  typedef struct packed {
    logic isZero;
    logic [intBits-1:0] intPart;
    logic [fracBits-1:0] frac;
  } logValue_t;

  // Opcode for combining the two logs
  typedef enum logic {
    opMul = 1'b0,
    opDiv = 1'b1
  } mulOp_t;

  // First antilog stage, mantissa plus shift and flags
  typedef struct packed {
    logic [mantBits-1:0] mantissa;
    logic [intBits-1:0] shiftCnt;
    logic isZero;
    logic saturate;
  } octaveStage_t;

endpackage

`default_nettype wire

// ==== design/log2Convert.sv ====
// One-cycle log2 of an unsigned operand; inWidth must be 64 or less, fraction is table-approximated
`timescale 1ns/1ns
`default_nettype none

module log2Convert #(
  parameter int inWidth = 16
) (
  input  logic clk,
  input  logic [inWidth-1:0] value,
  output logArithPkg::logValue_t logOut
);
  import logArithPkg::*;

  // Operand with zero fill below, for short operands
  localparam int extWidth = inWidth + fracBits;

  logic valueZero;
  logic [intBits-1:0] leadPos;
  logic [intBits-1:0] normShift;
  logic [extWidth-1:0] normValue;
  logic [fracBits-1:0] fracIndex;
  logic [fracBits-1:0] fracLut;

  ////////////////////////////////////////////////////////////////////////////
  // Leading-one detector
  ////////////////////////////////////////////////////////////////////////////

  // Highest set bit wins, scanned upward
  always_comb begin
    leadPos = '0;
    for (int i = 0; i < inWidth; i++) begin
      if (value[i]) begin
        leadPos = intBits'(i);
      end
    end
  end

  assign valueZero = (value == '0);

  // Move the leading one to the top bit
  assign normShift = intBits'(inWidth - 1) - leadPos;
  assign normValue = {value, {fracBits{1'b0}}} << normShift;

  // Six bits just below the leading one
  assign fracIndex = normValue[extWidth-2 -: fracBits];

  ////////////////////////////////////////////////////////////////////////////
  // Fraction table, 64 * log2(1 + k/64) rounded
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fracIndex)
      6'd0: fracLut = 6'd0;
      6'd1: fracLut = 6'd1;
      6'd2: fracLut = 6'd3;
      6'd3: fracLut = 6'd4;
      6'd4: fracLut = 6'd6;
      6'd5: fracLut = 6'd7;
      6'd6: fracLut = 6'd8;
      6'd7: fracLut = 6'd10;
      6'd8: fracLut = 6'd11;
      6'd9: fracLut = 6'd12;
      6'd10: fracLut = 6'd13;
      6'd11: fracLut = 6'd15;
      6'd12: fracLut = 6'd16;
      6'd13: fracLut = 6'd17;
      6'd14: fracLut = 6'd18;
      6'd15: fracLut = 6'd19;
      6'd16: fracLut = 6'd21;
      6'd17: fracLut = 6'd22;
      6'd18: fracLut = 6'd23;
      6'd19: fracLut = 6'd24;
      6'd20: fracLut = 6'd25;
      6'd21: fracLut = 6'd26;
      6'd22: fracLut = 6'd27;
      6'd23: fracLut = 6'd28;
      6'd24: fracLut = 6'd29;
      6'd25: fracLut = 6'd30;
      6'd26: fracLut = 6'd31;
      6'd27: fracLut = 6'd32;
      6'd28: fracLut = 6'd34;
      6'd29: fracLut = 6'd35;
      6'd30: fracLut = 6'd35;
      6'd31: fracLut = 6'd36;
      6'd32: fracLut = 6'd37;
      6'd33: fracLut = 6'd38;
      6'd34: fracLut = 6'd39;
      6'd35: fracLut = 6'd40;
      6'd36: fracLut = 6'd41;
      6'd37: fracLut = 6'd42;
      6'd38: fracLut = 6'd43;
      6'd39: fracLut = 6'd44;
      6'd40: fracLut = 6'd45;
      6'd41: fracLut = 6'd46;
      6'd42: fracLut = 6'd47;
      6'd43: fracLut = 6'd47;
      6'd44: fracLut = 6'd48;
      6'd45: fracLut = 6'd49;
      6'd46: fracLut = 6'd50;
      6'd47: fracLut = 6'd51;
      6'd48: fracLut = 6'd52;
      6'd49: fracLut = 6'd52;
      6'd50: fracLut = 6'd53;
      6'd51: fracLut = 6'd54;
      6'd52: fracLut = 6'd55;
      6'd53: fracLut = 6'd56;
      6'd54: fracLut = 6'd56;
      6'd55: fracLut = 6'd57;
      6'd56: fracLut = 6'd58;
      6'd57: fracLut = 6'd59;
      6'd58: fracLut = 6'd60;
      6'd59: fracLut = 6'd60;
      6'd60: fracLut = 6'd61;
      6'd61: fracLut = 6'd62;
      6'd62: fracLut = 6'd63;
      6'd63: fracLut = 6'd63;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Zero operand gives leadPos 0 and index 0, so payload is clean
  always_ff @(posedge clk) begin
    logOut <= '{isZero: valueZero, intPart: leadPos, frac: fracLut};
  end

endmodule

`default_nettype wire

// ==== design/logCombine.sv ====
// One-cycle add or subtract of two log values; saturate flags divide by zero and log sums past 64
`timescale 1ns/1ns
`default_nettype none

module logCombine (
  input  logic clk,
  input  logArithPkg::logValue_t logA,
  input  logArithPkg::logValue_t logB,
  input  logArithPkg::mulOp_t op,
  output logArithPkg::logValue_t logOut,
  output logic saturate
);
  import logArithPkg::*;

  // Top bit of each holds the carry or borrow
  logic [fracBits:0] fracSum;
  logic [intBits:0] intSum;
  logic [fracBits:0] fracDiff;
  logic [intBits:0] intDiff;
  logic [logBits-1:0] combined;
  logic resultZero;
  logic resultSat;

  // Multiply path, fraction carry ripples into the integer part
  assign fracSum = {1'b0, logA.frac} + {1'b0, logB.frac};
  assign intSum = {1'b0, logA.intPart} + {1'b0, logB.intPart}
                + {{intBits{1'b0}}, fracSum[fracBits]};

  // Divide path, fraction borrow taken from the integer part
  assign fracDiff = {1'b0, logA.frac} - {1'b0, logB.frac};
  assign intDiff = {1'b0, logA.intPart} - {1'b0, logB.intPart}
                 - {{intBits{1'b0}}, fracDiff[fracBits]};

  always_comb begin
    combined = '0;
    resultZero = 1'b0;
    resultSat = 1'b0;
    case (op)
      opMul: begin
        combined = {intSum[intBits-1:0], fracSum[fracBits-1:0]};
        resultZero = logA.isZero | logB.isZero;
        // Carry out means at least 2^64
        resultSat = ~resultZero & intSum[intBits];
      end
      opDiv: begin
        combined = {intDiff[intBits-1:0], fracDiff[fracBits-1:0]};
        if (logA.isZero) begin
          resultZero = 1'b1;
        end else if (logB.isZero) begin
          resultSat = 1'b1;
        end else if (intDiff[intBits]) begin
          // Quotient below one
          resultZero = 1'b1;
        end
      end
      default: begin
        resultZero = 1'b1;
      end
    endcase
  end

  // Registered combined log and flag
  always_ff @(posedge clk) begin
    logOut <= {resultZero, combined};
    saturate <= resultSat;
  end

endmodule

`default_nettype wire

// ==== design/pow2Convert.sv ====
// Two-cycle base-2 antilog, integer part only; outWidth must be 64 or less, larger values saturate
`timescale 1ns/1ns
`default_nettype none

module pow2Convert #(
  parameter int outWidth = 32
) (
  input  logic clk,
  input  logArithPkg::logValue_t logIn,
  input  logic saturate,
  output logic [outWidth-1:0] result
);
  import logArithPkg::*;

  // Hidden one and mantissa, room for the largest shift
  localparam int shiftWidth = mantBits + (2 ** intBits);
  // Integer bits left after the fraction drops
  localparam int intWidth = shiftWidth - mantBits;

  octaveStage_t stage1;
  logic [mantBits-1:0] octaveLut;
  logic [shiftWidth-1:0] shifted;
  logic [intWidth-1:0] intValue;
  logic overflow;

  ////////////////////////////////////////////////////////////////////////////
  // Octave table, (2^(k/64) - 1) * 2^23 rounded
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (logIn.frac)
      6'd0: octaveLut = 23'd0;
      6'd1: octaveLut = 23'd91346;
      6'd2: octaveLut = 23'd183687;
      6'd3: octaveLut = 23'd277033;
      6'd4: octaveLut = 23'd371395;
      6'd5: octaveLut = 23'd466786;
      6'd6: octaveLut = 23'd563215;
      6'd7: octaveLut = 23'd660693;
      6'd8: octaveLut = 23'd759234;
      6'd9: octaveLut = 23'd858847;
      6'd10: octaveLut = 23'd959546;
      6'd11: octaveLut = 23'd1061340;
      6'd12: octaveLut = 23'd1164243;
      6'd13: octaveLut = 23'd1268267;
      6'd14: octaveLut = 23'd1373424;
      6'd15: octaveLut = 23'd1479725;
      6'd16: octaveLut = 23'd1587184;
      6'd17: octaveLut = 23'd1695814;
      6'd18: octaveLut = 23'd1805626;
      6'd19: octaveLut = 23'd1916634;
      6'd20: octaveLut = 23'd2028850;
      6'd21: octaveLut = 23'd2142289;
      6'd22: octaveLut = 23'd2256963;
      6'd23: octaveLut = 23'd2372886;
      6'd24: octaveLut = 23'd2490071;
      6'd25: octaveLut = 23'd2608532;
      6'd26: octaveLut = 23'd2728283;
      6'd27: octaveLut = 23'd2849338;
      6'd28: octaveLut = 23'd2971711;
      6'd29: octaveLut = 23'd3095417;
      6'd30: octaveLut = 23'd3220470;
      6'd31: octaveLut = 23'd3346884;
      6'd32: octaveLut = 23'd3474675;
      6'd33: octaveLut = 23'd3603858;
      6'd34: octaveLut = 23'd3734447;
      6'd35: octaveLut = 23'd3866459;
      6'd36: octaveLut = 23'd3999908;
      6'd37: octaveLut = 23'd4134810;
      6'd38: octaveLut = 23'd4271181;
      6'd39: octaveLut = 23'd4409037;
      6'd40: octaveLut = 23'd4548394;
      6'd41: octaveLut = 23'd4689269;
      6'd42: octaveLut = 23'd4831678;
      6'd43: octaveLut = 23'd4975637;
      6'd44: octaveLut = 23'd5121164;
      6'd45: octaveLut = 23'd5268276;
      6'd46: octaveLut = 23'd5416990;
      6'd47: octaveLut = 23'd5567323;
      6'd48: octaveLut = 23'd5719293;
      6'd49: octaveLut = 23'd5872918;
      6'd50: octaveLut = 23'd6028216;
      6'd51: octaveLut = 23'd6185205;
      6'd52: octaveLut = 23'd6343903;
      6'd53: octaveLut = 23'd6504329;
      6'd54: octaveLut = 23'd6666503;
      6'd55: octaveLut = 23'd6830442;
      6'd56: octaveLut = 23'd6996167;
      6'd57: octaveLut = 23'd7163696;
      6'd58: octaveLut = 23'd7333050;
      6'd59: octaveLut = 23'd7504247;
      6'd60: octaveLut = 23'd7677309;
      6'd61: octaveLut = 23'd7852255;
      6'd62: octaveLut = 23'd8029107;
      6'd63: octaveLut = 23'd8207884;
    endcase
  end

  // Stage 1, table output with shift count and flags
  always_ff @(posedge clk) begin
    stage1 <= '{
      mantissa: octaveLut,
      shiftCnt: logIn.intPart,
      isZero: logIn.isZero,
      saturate: saturate
    };
  end

  ////////////////////////////////////////////////////////////////////////////
  // Barrel shifter and output stage
  ////////////////////////////////////////////////////////////////////////////

  // Hidden one restored above the mantissa
  assign shifted = {{(intWidth - 1){1'b0}}, 1'b1, stage1.mantissa} << stage1.shiftCnt;

  // Fraction bits dropped
  assign intValue = shifted[shiftWidth-1:mantBits];

  // Any set bit above the output width
  assign overflow = (intValue >> outWidth) != '0;

  // Zero flag first, payload may be stale then
  always_ff @(posedge clk) begin
    if (stage1.isZero) begin
      result <= '0;
    end else if (stage1.saturate || overflow) begin
      result <= '1;
    end else begin
      result <= intValue[outWidth-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== design/logArithTop.sv ====
// Approximate unsigned multiply and divide in the log domain; fixed 4-cycle latency, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module logArithTop #(
  parameter int inWidth = 16,
  parameter int outWidth = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic inValid,
  input  logic [inWidth-1:0] opA,
  input  logic [inWidth-1:0] opB,
  input  logArithPkg::mulOp_t op,
  output logic outValid,
  output logic [outWidth-1:0] result
);
  import logArithPkg::*;

  // Two log stages plus two antilog stages
  localparam int latency = 4;

  logic [latency-1:0] validPipe;
  mulOp_t opDelay;
  logValue_t logA;
  logValue_t logB;
  logValue_t logSum;
  logic combSat;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  // Valid strobe follows the data pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[latency-2:0], inValid};
    end
  end

  assign outValid = validPipe[latency-1];

  // Opcode lines up with the registered logs
  always_ff @(posedge clk) begin
    opDelay <= op;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  log2Convert #(.inWidth(inWidth)) u_logA (.clk(clk), .value(opA), .logOut(logA));

  log2Convert #(.inWidth(inWidth)) u_logB (.clk(clk), .value(opB), .logOut(logB));

  logCombine u_combine (
    .clk(clk),
    .logA(logA),
    .logB(logB),
    .op(opDelay),
    .logOut(logSum),
    .saturate(combSat)
  );

  pow2Convert #(.outWidth(outWidth)) u_pow2 (
    .clk(clk),
    .logIn(logSum),
    .saturate(combSat),
    .result(result)
  );

endmodule

`default_nettype wire

// ==== tb/logArithModel.svh ====
// Reference model, included inside the testbench module; needs inWidth and outWidth declared first
`ifndef LOG_ARITH_MODEL_SVH
`define LOG_ARITH_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Tables from real-number math
////////////////////////////////////////////////////////////////////////////

// 64 * log2(1 + k/64), rounded to nearest
function automatic int fracTable(int k);
  real v;
  v = 64.0 * $ln(1.0 + k / 64.0) / $ln(2.0);
  return $rtoi(v + 0.5);
endfunction

// (2^(k/64) - 1) * 2^23, rounded to nearest
function automatic int octaveTable(int k);
  real v;
  v = ($pow(2.0, k / 64.0) - 1.0) * 8388608.0;
  return $rtoi(v + 0.5);
endfunction

// Log2 in 1/64 steps, -1 for a zero operand
function automatic int logOf(logic [inWidth-1:0] x);
  int xi;
  int v;
  int lead;
  int idx;
  xi = int'(x);
  v = xi;
  lead = -1;
  while (v != 0) begin
    lead++;
    v = v >> 1;
  end
  if (lead < 0) return -1;
  // Six bits below the leading one, zero filled
  idx = (lead >= 6) ? (xi >> (lead - 6)) & 63 : (xi << (6 - lead)) & 63;
  return lead * 64 + fracTable(idx);
endfunction

// Expected DUT result for one request
function automatic logic [outWidth-1:0] expectedResult(logic [inWidth-1:0] a,
                                                       logic [inWidth-1:0] b, logic isDiv);
  int s;
  logic [127:0] full;
  if (a == '0) return '0;
  if (b == '0) return isDiv ? '1 : '0;
  s = isDiv ? logOf(a) - logOf(b) : logOf(a) + logOf(b);
  if (s < 0) return '0;
  if (s >= 64 * 64) return '1;
  // Hidden one, octave mantissa, shift, then drop 23 fraction bits
  full = 128'({1'b1, 23'(octaveTable(s % 64))}) << (s / 64);
  full = full >> 23;
  if ((full >> outWidth) != '0) return '1;
  return full[outWidth-1:0];
endfunction

`endif

// ==== tb/logArithTb.sv ====
// Directed testbench for logArithTop at 16-bit operands and 32-bit results; stops at the first error
`timescale 1ns/1ns
`default_nettype none

module logArithTb;
  import logArithPkg::*;

  localparam int inWidth = 16;
  localparam int outWidth = 32;
  // Longest wait for any result, in cycles
  localparam int timeoutCycles = 20;

  logic clk;
  logic reset;
  logic inValid;
  logic [inWidth-1:0] opA;
  logic [inWidth-1:0] opB;
  mulOp_t op;
  logic outValid;
  logic [outWidth-1:0] result;
  logic [31:0] rngState;
  // Expected results in request order
  logic [outWidth-1:0] expectQ[$];

  `include "logArithModel.svh"

  logArithTop #(.inWidth(inWidth), .outWidth(outWidth)) u_dut (
    .clk(clk), .reset(reset), .inValid(inValid), .opA(opA), .opB(opB),
    .op(op), .outValid(outValid), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextRandom(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic failAndStop();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      failAndStop();
    end
  endtask

  // Inputs change and outputs are read 10 ns after the edge
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  task automatic driveRequest(logic [inWidth-1:0] a, logic [inWidth-1:0] b, logic isDiv);
    inValid = 1'b1;
    opA = a;
    opB = b;
    op = isDiv ? opDiv : opMul;
  endtask

  // One request, then wait for its strobe
  task automatic runOne(logic [inWidth-1:0] a, logic [inWidth-1:0] b, logic isDiv,
                        logic [outWidth-1:0] expected);
    int cycles;
    cycles = 0;
    driveRequest(a, b, isDiv);
    nextCycle();
    inValid = 1'b0;
    while (outValid !== 1'b1) begin
      if (cycles == timeoutCycles) begin
        $display("No result arrived for %0d %s %0d", a, isDiv ? "div" : "mul", b);
        failAndStop();
      end
      nextCycle();
      cycles++;
    end
    checkValue("result", result, expected);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testLatency();
    for (int i = 0; i < 5; i++) begin
      checkValue("outValid", 32'(outValid), 0);
      nextCycle();
    end
    driveRequest(16'd3, 16'd5, 1'b0);
    nextCycle();
    inValid = 1'b0;
    // Strobe only on the fourth cycle
    for (int i = 1; i <= 6; i++) begin
      checkValue("outValid", 32'(outValid), (i == 4) ? 1 : 0);
      if (i == 4) checkValue("result", result, expectedResult(16'd3, 16'd5, 1'b0));
      nextCycle();
    end
  endtask

  task automatic testPowers();
    runOne(16'd256, 16'd64, 1'b0, 32'd16384);
    runOne(16'd4096, 16'd16, 1'b1, 32'd256);
    for (int i = 0; i < inWidth; i++) begin
      for (int j = 0; j < inWidth; j++) begin
        runOne(16'(1 << i), 16'(1 << j), 1'b0, 32'(1) << (i + j));
        if (i >= j) runOne(16'(1 << i), 16'(1 << j), 1'b1, 32'(1) << (i - j));
      end
    end
  endtask

  task automatic testZeros();
    runOne(16'd0, 16'd123, 1'b0, '0);
    runOne(16'd77, 16'd0, 1'b0, '0);
    runOne(16'd0, 16'd5, 1'b1, '0);
    runOne(16'd0, 16'd0, 1'b1, '0);
    runOne(16'd100, 16'd0, 1'b1, '1);
    runOne(16'd3, 16'd200, 1'b1, '0);
  endtask

  // With 16-bit operands the log sum stays below 2^32, so only divide by zero saturates
  task automatic testSaturation();
    runOne(16'hffff, 16'hffff, 1'b0, expectedResult(16'hffff, 16'hffff, 1'b0));
    runOne(16'hffff, 16'h8000, 1'b0, expectedResult(16'hffff, 16'h8000, 1'b0));
    runOne(16'hffff, 16'd1, 1'b1, expectedResult(16'hffff, 16'd1, 1'b1));
    runOne(16'hffff, 16'd0, 1'b1, '1);
  endtask

  // Back to back, one request per cycle
  task automatic testRandom(int count);
    logic [inWidth-1:0] a;
    logic [inWidth-1:0] b;
    int cycles;
    for (int i = 0; i < count; i++) begin
      rngState = nextRandom(rngState);
      a = rngState[15:0] >> rngState[19:16];
      rngState = nextRandom(rngState);
      b = rngState[15:0] >> rngState[19:16];
      expectQ.push_back(expectedResult(a, b, rngState[20]));
      driveRequest(a, b, rngState[20]);
      nextCycle();
      // Four requests in flight once the pipe is full
      if (i >= 3) begin
        checkValue("outValid", 32'(outValid), 1);
        checkValue("result", result, expectQ.pop_front());
      end
    end
    inValid = 1'b0;
    cycles = 0;
    while (expectQ.size() != 0) begin
      if (cycles == timeoutCycles) begin
        $display("No result arrived for %0d queued random requests", expectQ.size());
        failAndStop();
      end
      nextCycle();
      cycles++;
      if (outValid === 1'b1) checkValue("result", result, expectQ.pop_front());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    inValid = 1'b0;
    opA = '0;
    opB = '0;
    op = opMul;
    rngState = 32'hb869_8af3;
    repeat (10) @(posedge clk);
    #10;
    reset = 1'b0;
    testLatency();
    testPowers();
    testZeros();
    testSaturation();
    testRandom(200);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
design/logArithPkg.sv
design/log2Convert.sv
design/logCombine.sv
design/pow2Convert.sv
design/logArithTop.sv
tb/logArithTb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -f src.f --top-module logArithTb -o logArithSim
	@out="$$(./obj_dir/logArithSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module logArithTb

clean:
	rm -rf obj_dir
